// ==== hdl/frame_store_params.svh ====
`ifndef FRAME_STORE_PARAMS_SVH
`define FRAME_STORE_PARAMS_SVH

// One RGB pixel, 8 bits per channel
`define PIXEL_BITS 24

// Pixels moved by one wide line burst
`define BURST_PIXELS 64

// Frame size, kept a multiple of the burst length and the bank count
`define FRAME_PIXELS 1024

// Frame is split over this many equal banks
`define BANK_COUNT 4

// Rows in each bank
`define BANK_DEPTH (`FRAME_PIXELS / `BANK_COUNT)

// Width of one burst word
`define BURST_BITS (`BURST_PIXELS * `PIXEL_BITS)

`endif

// ==== hdl/pixel_pkg.sv ====
`default_nettype none

`include "frame_store_params.svh"

package pixel_pkg;

	// Colour channels, red in the top byte and blue in the bottom byte
	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_channels_t;

	// One pixel word
	// Store moves it as raw bits, luma path looks at the channels
	typedef union packed {
		logic [`PIXEL_BITS-1:0] raw;
		rgb_channels_t channels;
	} rgb_pixel_u;

	// Luminance byte
	typedef logic [7:0] luma_t;

endpackage

`default_nettype wire

// ==== hdl/frame_pkg.sv ====
`default_nettype none

`include "frame_store_params.svh"

package frame_pkg;

	// Pixel address within one frame
	typedef logic [$clog2(`FRAME_PIXELS)-1:0] pixel_index_t;

	// One extra bit to catch the carry past the frame end
	typedef logic [$clog2(`FRAME_PIXELS):0] pixel_sum_t;

	// Bank number
	typedef logic [$clog2(`BANK_COUNT)-1:0] bank_index_t;

	// Row inside one bank
	typedef logic [$clog2(`BANK_DEPTH)-1:0] bank_row_t;

	// Pixel position inside a burst word
	typedef logic [$clog2(`BURST_PIXELS)-1:0] burst_slot_t;

endpackage

`default_nettype wire

// ==== hdl/burst_packer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "frame_store_params.svh"

module burst_packer
	import pixel_pkg::*, frame_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire rgb_pixel_u pixel_in,
	input wire logic pixel_valid,
	input wire logic frame_start,
	output logic [`BURST_BITS-1:0] write_data,
	output pixel_index_t write_address,
	output logic write_enable,
	output logic frame_written
);

	// Slot the next strobed pixel will land in
	burst_slot_t slot;
	logic slot_last;
	logic burst_full;
	logic last_burst;

	assign slot_last = (slot == burst_slot_t'(`BURST_PIXELS - 1));

	// Final pixel of a burst arrives this cycle
	assign burst_full = pixel_valid && slot_last;

	// Burst being filled is the one at the frame end
	assign last_burst = (write_address == pixel_index_t'(`FRAME_PIXELS - `BURST_PIXELS));

	// Burst register doubles as the write word
	// New pixel enters at the top, so the first one ends up in slot 0
	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			write_data <= {pixel_in.raw, write_data[`BURST_BITS-1:`PIXEL_BITS]};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			slot <= '0;
			write_address <= '0;
			write_enable <= 1'b0;
			frame_written <= 1'b0;
		end else begin
			// One-cycle write right after the burst fills
			write_enable <= burst_full;
			frame_written <= burst_full && last_burst;

			if (frame_start) begin
				// Restart at the top of the frame
				slot <= '0;
				write_address <= '0;
			end else begin
				if (pixel_valid) begin
					if (slot_last) begin
						slot <= '0;
					end else begin
						slot <= slot + 1'b1;
					end
				end

				// Address moves on once the store has taken the burst
				if (write_enable) begin
					if (last_burst) begin
						write_address <= '0;
					end else begin
						write_address <= pixel_index_t'(write_address + `BURST_PIXELS);
					end
				end
			end
		end
	end

	// Restart only between pixels, never on top of a strobe
	assert property (@(posedge clk) disable iff (reset)
		!(frame_start && pixel_valid))
		else $error("frame_start arrived together with pixel_valid");

endmodule

`default_nettype wire

// ==== hdl/banked_sram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "frame_store_params.svh"

module banked_sram
	import pixel_pkg::*, frame_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic [`BURST_BITS-1:0] write_data,
	input wire pixel_index_t write_address,
	input wire logic write_enable,
	input wire pixel_index_t read_address,
	input wire logic read_enable,
	output logic [`BURST_BITS-1:0] read_data
);

	// Frame storage, one array per bank
	rgb_pixel_u bank_mem [`BANK_COUNT][`BANK_DEPTH];

	// Wrapped pixel index of every slot, write and read side
	pixel_index_t write_index [`BURST_PIXELS];
	pixel_index_t read_index [`BURST_PIXELS];

	// Bank and row of every slot
	bank_index_t write_bank [`BURST_PIXELS];
	bank_row_t write_row [`BURST_PIXELS];
	bank_index_t read_bank [`BURST_PIXELS];
	bank_row_t read_row [`BURST_PIXELS];

	// Base plus slot offset, folded back past the frame end
	function automatic pixel_index_t wrap_index(input pixel_index_t base,
		input burst_slot_t offset);
		pixel_sum_t sum;
		sum = pixel_sum_t'(base) + pixel_sum_t'(offset);
		if (sum >= `FRAME_PIXELS) begin
			sum = sum - pixel_sum_t'(`FRAME_PIXELS);
		end
		return pixel_index_t'(sum);
	endfunction

	// Address decode for all slots at once
	always_comb begin
		for (int i = 0; i < `BURST_PIXELS; i++) begin
			write_index[i] = wrap_index(write_address, burst_slot_t'(i));
			read_index[i] = wrap_index(read_address, burst_slot_t'(i));
			// Upper part of the index picks the bank, the rest the row
			write_bank[i] = bank_index_t'(write_index[i] / `BANK_DEPTH);
			write_row[i] = bank_row_t'(write_index[i] % `BANK_DEPTH);
			read_bank[i] = bank_index_t'(read_index[i] / `BANK_DEPTH);
			read_row[i] = bank_row_t'(read_index[i] % `BANK_DEPTH);
		end
	end

	// Write port
	always_ff @(posedge clk) begin
		if (reset) begin
			// Whole frame goes white
			for (int b = 0; b < `BANK_COUNT; b++) begin
				for (int r = 0; r < `BANK_DEPTH; r++) begin
					bank_mem[b][r].raw <= '1;
				end
			end
		end else if (write_enable) begin
			for (int i = 0; i < `BURST_PIXELS; i++) begin
				bank_mem[write_bank[i]][write_row[i]].raw <=
					write_data[i*`PIXEL_BITS +: `PIXEL_BITS];
			end
		end
	end

	// Read port, old contents on a same-cycle write
	// Holds its word until the next read
	always_ff @(posedge clk) begin
		if (read_enable) begin
			for (int i = 0; i < `BURST_PIXELS; i++) begin
				read_data[i*`PIXEL_BITS +: `PIXEL_BITS] <=
					bank_mem[read_bank[i]][read_row[i]].raw;
			end
		end
	end

	// Producer only writes whole aligned bursts
	assert property (@(posedge clk) disable iff (reset)
		write_enable |-> ((write_address % `BURST_PIXELS) == 0))
		else $error("unaligned burst write at %0d", write_address);

endmodule

`default_nettype wire

// ==== hdl/luma_reader.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "frame_store_params.svh"

module luma_reader
	import pixel_pkg::*, frame_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic read_start,
	input wire pixel_index_t read_base,
	input wire logic [`BURST_BITS-1:0] read_data,
	output pixel_index_t read_address,
	output logic read_enable,
	output luma_t luma,
	output logic luma_valid,
	output logic read_done
);

	// High while read_data slots are being converted
	logic unpack_active;
	burst_slot_t slot;
	pixel_index_t pixel_count;
	rgb_pixel_u current_pixel;
	logic slot_last;
	logic last_pixel;
	logic issue_next;
	pixel_sum_t next_sum;
	pixel_index_t next_address;

	// Integer luma weights out of 256
	function automatic luma_t luma_of(input rgb_pixel_u px);
		logic [15:0] weighted;
		weighted = 16'd77 * 16'(px.channels.red)
			+ 16'd150 * 16'(px.channels.green)
			+ 16'd29 * 16'(px.channels.blue);
		return luma_t'(weighted >> 8);
	endfunction

	// Slot under conversion this cycle
	assign current_pixel.raw = read_data[slot*`PIXEL_BITS +: `PIXEL_BITS];

	assign slot_last = (slot == burst_slot_t'(`BURST_PIXELS - 1));
	assign last_pixel = (pixel_count == pixel_index_t'(`FRAME_PIXELS - 1));

	// Start of the following burst, wrapped at the frame end
	assign next_sum = pixel_sum_t'(read_address) + pixel_sum_t'(`BURST_PIXELS);
	assign next_address = (next_sum >= `FRAME_PIXELS) ?
		pixel_index_t'(next_sum - pixel_sum_t'(`FRAME_PIXELS)) : pixel_index_t'(next_sum);

	// Fetch two slots before the end so the new word lands right after slot 63
	assign issue_next = unpack_active
		&& (slot == burst_slot_t'(`BURST_PIXELS - 2))
		&& (pixel_count < pixel_index_t'(`FRAME_PIXELS - `BURST_PIXELS));

	always_ff @(posedge clk) begin
		if (reset) begin
			read_enable <= 1'b0;
			read_address <= '0;
			unpack_active <= 1'b0;
			slot <= '0;
			pixel_count <= '0;
			luma_valid <= 1'b0;
			read_done <= 1'b0;
		end else begin
			// Luma register is loaded whenever a slot is converted
			luma_valid <= unpack_active;
			read_done <= unpack_active && last_pixel;

			// Burst fetches, first one straight from the requested base
			if (read_start) begin
				read_enable <= 1'b1;
				read_address <= read_base;
			end else if (issue_next) begin
				read_enable <= 1'b1;
				read_address <= next_address;
			end else begin
				read_enable <= 1'b0;
			end

			// First fetch starts conversion, last pixel ends it
			if (read_enable && !unpack_active) begin
				unpack_active <= 1'b1;
			end else if (unpack_active && last_pixel) begin
				unpack_active <= 1'b0;
			end

			// Walk the slots, counters are back at zero for the next frame
			if (unpack_active) begin
				if (last_pixel) begin
					slot <= '0;
					pixel_count <= '0;
				end else begin
					slot <= slot_last ? '0 : slot + 1'b1;
					pixel_count <= pixel_count + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (unpack_active) begin
			luma <= luma_of(current_pixel);
		end
	end

	// A new read waits until the previous frame has been fetched and converted
	assert property (@(posedge clk) disable iff (reset)
		read_start |-> !(read_enable || unpack_active))
		else $error("read_start during a frame read");

endmodule

`default_nettype wire

// ==== hdl/frame_store_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "frame_store_params.svh"

module frame_store_top
	import pixel_pkg::*, frame_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire rgb_pixel_u pixel_in,
	input wire logic pixel_valid,
	input wire logic frame_start,
	input wire logic read_start,
	input wire pixel_index_t read_base,
	output luma_t luma,
	output logic luma_valid,
	output logic frame_written,
	output logic read_done
);

	// Producer side of the store
	logic [`BURST_BITS-1:0] write_data;
	pixel_index_t write_address;
	logic write_enable;

	// Consumer side of the store
	logic [`BURST_BITS-1:0] read_data;
	pixel_index_t read_address;
	logic read_enable;

	burst_packer packer (
		.clk(clk),
		.reset(reset),
		.pixel_in(pixel_in),
		.pixel_valid(pixel_valid),
		.frame_start(frame_start),
		.write_data(write_data),
		.write_address(write_address),
		.write_enable(write_enable),
		.frame_written(frame_written)
	);

	// Separate write and read addresses, no arbitration
	banked_sram store (
		.clk(clk),
		.reset(reset),
		.write_data(write_data),
		.write_address(write_address),
		.write_enable(write_enable),
		.read_address(read_address),
		.read_enable(read_enable),
		.read_data(read_data)
	);

	luma_reader reader (
		.clk(clk),
		.reset(reset),
		.read_start(read_start),
		.read_base(read_base),
		.read_data(read_data),
		.read_address(read_address),
		.read_enable(read_enable),
		.luma(luma),
		.luma_valid(luma_valid),
		.read_done(read_done)
	);

endmodule

`default_nettype wire

// ==== verif/clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
	parameter int PERIOD_NS = 100,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic reset
);

	// Free-running clock, low for the first half period
	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk = ~clk;
		end
	end

	// Reset spans the first rising edges and drops on a falling edge
	initial begin
		reset <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== verif/frame_store_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "frame_store_params.svh"

module frame_store_tb
	import pixel_pkg::*, frame_pkg::*;
();

	// Longest test is a sparse write plus one full read
	localparam int TEST_CYCLE_LIMIT = 4 * `FRAME_PIXELS + 200;
	// First luma shows up this many cycles after read_start
	localparam int READ_LATENCY = 3;

	logic clk;
	logic reset;

	// DUT inputs
	rgb_pixel_u pixel_in;
	logic pixel_valid;
	logic frame_start;
	logic read_start;
	pixel_index_t read_base;

	// DUT outputs
	luma_t luma;
	logic luma_valid;
	logic frame_written;
	logic read_done;

	// Expected frame contents
	rgb_pixel_u frame_model [`FRAME_PIXELS];

	// Stimulus thread state
	int driver_errors;
	int written_pulses;
	int read_token;
	int check_base;
	int start_cycle;
	int test_start_cycle;
	int test_number;
	int tests_failed;
	int errors_at_start;

	// Comparing process state, zero at time 0
	int compare_errors;
	int reads_completed;
	int last_token;
	int seen_count;
	bit armed;

	// Rising edges since time 0
	int cycle;

	clock_gen #(
		.PERIOD_NS(100),
		.RESET_CYCLES(2)
	) clocks (
		.clk(clk),
		.reset(reset)
	);

	frame_store_top dut (
		.clk(clk),
		.reset(reset),
		.pixel_in(pixel_in),
		.pixel_valid(pixel_valid),
		.frame_start(frame_start),
		.read_start(read_start),
		.read_base(read_base),
		.luma(luma),
		.luma_valid(luma_valid),
		.frame_written(frame_written),
		.read_done(read_done)
	);

	// Weights 77, 150 and 29 out of 256
	function automatic luma_t expected_luma(input rgb_pixel_u px);
		int sum;
		sum = 77 * int'(px.channels.red) + 150 * int'(px.channels.green)
			+ 29 * int'(px.channels.blue);
		return luma_t'(sum >> 8);
	endfunction

	// Falling edge, inputs change here and outputs are stable
	task automatic step();
		@(negedge clk);
		if (frame_written) begin
			written_pulses++;
		end
	endtask

	// One frame of random pixels, up to max_gap idle cycles before each strobe
	// Stray pixels before frame_start leave a partial burst and a moved address behind
	task automatic write_frame(input int max_gap, input int stray_pixels);
		logic [31:0] draw;
		int gap;
		int wait_count;
		written_pulses = 0;
		for (int s = 0; s < stray_pixels; s++) begin
			draw = $urandom;
			pixel_in.raw = draw[`PIXEL_BITS-1:0];
			pixel_valid = 1'b1;
			step();
			pixel_valid = 1'b0;
		end
		step();
		frame_start = 1'b1;
		step();
		frame_start = 1'b0;
		for (int p = 0; p < `FRAME_PIXELS; p++) begin
			draw = $urandom;
			gap = int'(draw % (max_gap + 1));
			repeat (gap) begin
				step();
			end
			draw = $urandom;
			frame_model[p].raw = draw[`PIXEL_BITS-1:0];
			pixel_in = frame_model[p];
			pixel_valid = 1'b1;
			step();
			pixel_valid = 1'b0;
		end
		// frame_written comes with the last burst write
		wait_count = 0;
		while (written_pulses == 0 && wait_count < 8) begin
			step();
			wait_count++;
		end
		// Quiet cycles to catch a second pulse
		step();
		step();
		if (written_pulses != 1) begin
			$display("frame_written pulsed %0d times for one frame", written_pulses);
			driver_errors++;
		end
	endtask

	// Start a frame read and wait for the comparing process to finish it
	task automatic read_frame(input int base);
		step();
		read_base = pixel_index_t'(base);
		read_start = 1'b1;
		check_base <= base;
		start_cycle <= cycle;
		read_token <= read_token + 1;
		step();
		read_start = 1'b0;
		while (reads_completed != read_token) begin
			step();
		end
	endtask

	task automatic begin_test();
		test_number++;
		test_start_cycle = cycle;
		errors_at_start = driver_errors + compare_errors;
	endtask

	task automatic end_test(input string name);
		int errors;
		errors = driver_errors + compare_errors - errors_at_start;
		if (errors == 0) begin
			$display("test %0d %s: ok", test_number, name);
		end else begin
			$display("test %0d %s: failed with %0d errors", test_number, name, errors);
			tests_failed++;
		end
	endtask

	// Checks every luma against the model at (base + n) mod frame size
	always @(negedge clk) begin
		int index;
		int fails;
		luma_t want;
		fails = 0;
		if (!reset) begin
			if (!armed) begin
				// Stream must be idle between reads
				if (luma_valid || read_done) begin
					$display("luma_valid or read_done high with no read in progress");
					fails++;
				end
				if (read_token != last_token) begin
					armed <= 1'b1;
					seen_count <= 0;
					last_token <= read_token;
				end
			end else if (seen_count == `FRAME_PIXELS) begin
				// One cycle past the last pixel
				if (luma_valid || read_done) begin
					$display("luma stream still running after %0d pixels", seen_count);
					fails++;
				end
				armed <= 1'b0;
				reads_completed <= reads_completed + 1;
			end else if (luma_valid) begin
				if (seen_count == 0 && cycle - start_cycle != READ_LATENCY) begin
					$display("first luma came %0d cycles after read_start, not %0d",
						cycle - start_cycle, READ_LATENCY);
					fails++;
				end
				index = (check_base + seen_count) % `FRAME_PIXELS;
				want = expected_luma(frame_model[index]);
				if (luma !== want) begin
					$display("CHECK FAILED luma at pixel %0d: got %h expected %h",
						index, luma, want);
					fails++;
				end
				if (read_done !== (seen_count == `FRAME_PIXELS - 1)) begin
					$display("CHECK FAILED read_done at luma %0d: got %h expected %h",
						seen_count, read_done, seen_count == `FRAME_PIXELS - 1);
					fails++;
				end
				seen_count <= seen_count + 1;
			end else if (seen_count > 0) begin
				// A gap ends the read early
				$display("luma_valid dropped after %0d pixels", seen_count);
				fails++;
				armed <= 1'b0;
				reads_completed <= reads_completed + 1;
			end else if (read_done) begin
				$display("read_done pulsed before any luma");
				fails++;
			end
		end
		compare_errors <= compare_errors + fails;
	end

	// Cycle counter and per-test watchdog
	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle - test_start_cycle > TEST_CYCLE_LIMIT) begin
			$display("Timeout in test %0d after %0d cycles", test_number, TEST_CYCLE_LIMIT);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		logic [31:0] seed_draw;
		seed_draw = $urandom(32'h8c65_1a61);
		pixel_in = '0;
		pixel_valid = 1'b0;
		frame_start = 1'b0;
		read_start = 1'b0;
		read_base = '0;
		driver_errors = 0;
		written_pulses = 0;
		test_start_cycle = 0;
		test_number = 0;
		tests_failed = 0;
		errors_at_start = 0;
		// Store comes out of reset white
		for (int p = 0; p < `FRAME_PIXELS; p++) begin
			frame_model[p].raw = '1;
		end
		// Reset is raised at time 0, count it out from there
		wait (reset === 1'b1);
		while (reset) begin
			step();
		end

		begin_test();
		read_frame(0);
		end_test("white after reset");

		begin_test();
		write_frame(0, 0);
		read_frame(0);
		end_test("written frame read back");

		// Crosses every bank border and wraps past the frame end
		begin_test();
		read_frame(37);
		end_test("unaligned base 37");

		// Latency, gapless run and read_done are checked on every read
		begin_test();
		read_frame(1000);
		end_test("read timing");

		// More than one burst of stray pixels, so frame_start has to clear slot and address
		begin_test();
		write_frame(2, 70);
		read_frame(0);
		end_test("sparse strobes");

		$display("%0d tests run, %0d failed, %0d errors", test_number, tests_failed,
			driver_errors + compare_errors);
		if (tests_failed == 0 && driver_errors + compare_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/pixel_pkg.sv
hdl/frame_pkg.sv
hdl/burst_packer.sv
hdl/banked_sram.sv
hdl/luma_reader.sv
hdl/frame_store_top.sv
verif/clock_gen.sv
verif/frame_store_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the frame store testbench with Verilator and runs it.
# Exits non-zero when the build, the run or the testbench fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=frame_store_tb

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" -f verilog.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
	echo "Testbench reported failure, see $LOG"
	exit 1
fi

echo "Simulation finished, log in $LOG"
exit 0
